// ==== verilog/isaPkg.sv ====
package isaPkg;

    localparam int dataWidth = 16;
    localparam int shiftBits = $clog2(dataWidth);

    // opcode classes handed over by decode
    typedef enum logic [4:0] {
        rArith,
        rShift,
        addI,
        subI,
        xorI,
        andnI,
        rolI,
        sllI,
        rorI,
        srlI,
        seqOp,
        sltOp,
        sleOp,
        scoOp,
        btrOp,
        lbiOp,
        slbiOp,
        loadOp,
        storeOp,
        stuOp,
        branchOp,
        jOp,
        jrOp,
        jalOp,
        jalrOp
    } opClassT;

    typedef logic [1:0] aluFuncT;

    // function field of rArith
    localparam aluFuncT fnAdd  = 2'd0;
    localparam aluFuncT fnSub  = 2'd1;
    localparam aluFuncT fnXor  = 2'd2;
    localparam aluFuncT fnAndn = 2'd3;

    // function field of rShift
    localparam aluFuncT fnRol = 2'd0;
    localparam aluFuncT fnSll = 2'd1;
    localparam aluFuncT fnRor = 2'd2;
    localparam aluFuncT fnSrl = 2'd3;

    typedef enum logic [3:0] {
        opAdd, opAnd, opOr, opXor, opRol, opSll, opRor, opSrl
    } aluOpT;

    // where the stage result comes from
    typedef enum logic [3:0] {
        selAlu, selSlbi, selImm, selSlt, selSle, selSeq, selSco, selBtr, selLink, selStu
    } resSelT;

    typedef enum logic [1:0] {
        eqz, nez, ltz, gez
    } branchCondT;

endpackage

// ==== verilog/pipePkg.sv ====
package pipePkg;

    // bundle registered at the end of decode
    typedef struct packed {
        logic [isaPkg::dataWidth-1:0] pc2;
        logic [isaPkg::dataWidth-1:0] rd1;
        logic [isaPkg::dataWidth-1:0] rd2;
        logic [isaPkg::dataWidth-1:0] imm;
        isaPkg::opClassT              opClass;
        isaPkg::aluFuncT              aluFunc;
        isaPkg::branchCondT           branchCond;
        logic                         aluSrc;
        // writeback controls
        logic                         regWrite;
        logic                         memToReg;
        // memory controls
        logic                         memWrite;
        logic                         memRead;
        logic                         dump;
    } idExT;

    // bundle leaving execute
    typedef struct packed {
        logic [isaPkg::dataWidth-1:0] aluResult;
        logic [isaPkg::dataWidth-1:0] rd2;
        logic [isaPkg::dataWidth-1:0] imm;
        logic [isaPkg::dataWidth-1:0] nextPc;
        // fetch takes nextPc when set
        logic                         redirect;
        logic                         memToReg;
        logic                         memWrite;
        logic                         memRead;
        logic                         dump;
        logic                         regWrite;
        logic                         err;
    } exMemT;

endpackage

// ==== verilog/aluCtrl.sv ====
`timescale 1ns/1ps

module aluCtrl (
    input  isaPkg::opClassT opClass,
    input  isaPkg::aluFuncT aluFunc,
    output isaPkg::aluOpT   aluOp,
    output logic            invB,
    output isaPkg::resSelT  resSel,
    output logic            illegal
);
    import isaPkg::*;

    always_comb begin
        aluOp   = opAdd;
        invB    = 1'b0;
        resSel  = selAlu;
        illegal = 1'b0;
        case (opClass)
            rArith: begin
                case (aluFunc)
                    fnAdd:  aluOp = opAdd;
                    fnSub:  invB = 1'b1;
                    fnXor:  aluOp = opXor;
                    fnAndn: aluOp = opAnd;
                endcase
            end
            rShift: begin
                case (aluFunc)
                    fnRol: aluOp = opRol;
                    fnSll: aluOp = opSll;
                    fnRor: aluOp = opRor;
                    fnSrl: aluOp = opSrl;
                endcase
            end
            addI, branchOp, jOp, jrOp: aluOp = opAdd;
            subI:   invB = 1'b1;
            xorI:   aluOp = opXor;
            andnI:  aluOp = opAnd;
            rolI:   aluOp = opRol;
            sllI:   aluOp = opSll;
            rorI:   aluOp = opRor;
            srlI:   aluOp = opSrl;
            // compares still run a subtract so the flags track them
            seqOp: begin
                invB   = 1'b1;
                resSel = selSeq;
            end
            sltOp: begin
                invB   = 1'b1;
                resSel = selSlt;
            end
            sleOp: begin
                invB   = 1'b1;
                resSel = selSle;
            end
            scoOp:  resSel = selSco;
            btrOp:  resSel = selBtr;
            lbiOp:  resSel = selImm;
            slbiOp: resSel = selSlbi;
            loadOp, storeOp, stuOp: resSel = selStu;
            jalOp, jalrOp: resSel = selLink;
            default: illegal = 1'b1;
        endcase
    end

    // inversion only makes sense on the adder path
    always_comb begin
        assert final (!invB || aluOp == opAdd)
            else $error("aluCtrl: invB set with aluOp %s", aluOp.name());
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [isaPkg::dataWidth-1:0] a,
    input  logic [isaPkg::dataWidth-1:0] b,
    input  isaPkg::aluOpT                aluOp,
    input  logic                         invB,
    output logic [isaPkg::dataWidth-1:0] result,
    output logic                         zero,
    output logic                         neg,
    output logic                         ofl,
    output logic                         carry
);
    import isaPkg::*;

    logic [dataWidth-1:0]   bAdd;
    logic [dataWidth-1:0]   sum;
    logic [shiftBits-1:0]   shAmt;
    logic [2*dataWidth-1:0] rolWide;
    logic [2*dataWidth-1:0] rorWide;

    // subtract is a + ~b + 1
    assign bAdd = invB ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, bAdd} + {{dataWidth{1'b0}}, invB};

    // operands agree in sign, sum does not
    assign ofl = (a[dataWidth-1] == bAdd[dataWidth-1]) &&
                 (sum[dataWidth-1] != a[dataWidth-1]);

    assign shAmt = b[shiftBits-1:0];

    // rotates via a doubled copy of a
    assign rolWide = {a, a} << shAmt;
    assign rorWide = {a, a} >> shAmt;

    always_comb begin
        case (aluOp)
            opAdd: result = sum;
            // the ISA only has the and-not form
            opAnd: result = a & ~b;
            opOr:  result = a | b;
            opXor: result = a ^ b;
            opRol: result = rolWide[2*dataWidth-1:dataWidth];
            opSll: result = a << shAmt;
            opRor: result = rorWide[dataWidth-1:0];
            opSrl: result = a >> shAmt;
            default: result = sum;
        endcase
    end

    assign zero = (result == '0);
    assign neg  = result[dataWidth-1];

endmodule

// ==== verilog/branchCtrl.sv ====
`timescale 1ns/1ps

module branchCtrl (
    input  logic                         isBranch,
    input  logic                         isJump,
    input  isaPkg::branchCondT           branchCond,
    input  logic [isaPkg::dataWidth-1:0] rd1,
    output logic                         takeBranch
);
    import isaPkg::*;

    logic condMet;

    // zero and sign tests on rd1
    always_comb begin
        case (branchCond)
            eqz:     condMet = (rd1 == '0);
            nez:     condMet = (rd1 != '0);
            ltz:     condMet = rd1[dataWidth-1];
            default: condMet = !rd1[dataWidth-1];
        endcase
    end

    assign takeBranch = isJump | (isBranch & condMet);

    // both come from one opcode class in execute
    always_comb begin
        assert final (!(isBranch && isJump))
            else $error("branchCtrl: branch and jump flagged together");
    end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic           clk,
    input  logic           reset,
    input  pipePkg::idExT  idEx,
    output pipePkg::exMemT exMem
);
    import isaPkg::*;
    import pipePkg::*;

    aluOpT                aluOp;
    logic                 invB;
    resSelT               resSel;
    logic                 illegal;
    logic [dataWidth-1:0] bOperand;
    logic [dataWidth-1:0] aluOut;
    logic                 aluZero;
    logic                 aluNeg;
    logic                 aluOfl;
    logic                 aluCarry;
    logic                 isBranch;
    logic                 isJump;
    logic                 isRegJump;
    logic                 takeBranch;
    logic [dataWidth-1:0] targetBase;
    logic [dataWidth-1:0] target;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] slbiOut;
    logic [dataWidth-1:0] btrOut;
    logic [dataWidth:0]   scoSum;
    logic                 sltBit;
    logic                 sleBit;
    logic                 seqBit;
    logic                 scoBit;
    logic [dataWidth-1:0] result;
    exMemT                exMemNext;

    aluCtrl aluCtrlInst (
        .opClass (idEx.opClass),
        .aluFunc (idEx.aluFunc),
        .aluOp   (aluOp),
        .invB    (invB),
        .resSel  (resSel),
        .illegal (illegal)
    );

    // branches pass rd1 straight through the adder
    assign bOperand = (idEx.opClass == branchOp) ? '0 :
                      (idEx.aluSrc ? idEx.imm : idEx.rd2);

    alu aluInst (
        .a      (idEx.rd1),
        .b      (bOperand),
        .aluOp  (aluOp),
        .invB   (invB),
        .result (aluOut),
        .zero   (aluZero),
        .neg    (aluNeg),
        .ofl    (aluOfl),
        .carry  (aluCarry)
    );

    assign isBranch  = (idEx.opClass == branchOp);
    assign isJump    = idEx.opClass inside {jOp, jrOp, jalOp, jalrOp};
    assign isRegJump = idEx.opClass inside {jrOp, jalrOp};

    branchCtrl branchCtrlInst (
        .isBranch   (isBranch),
        .isJump     (isJump),
        .branchCond (idEx.branchCond),
        .rd1        (idEx.rd1),
        .takeBranch (takeBranch)
    );

    // target adder
    assign targetBase = isRegJump ? idEx.rd1 : idEx.pc2;
    assign target     = targetBase + idEx.imm;

    // special results, always against rd2 whatever aluSrc says
    assign memAddr = idEx.rd1 + idEx.imm;
    assign slbiOut = (idEx.rd1 << 8) | idEx.imm;
    assign btrOut  = {<<{idEx.rd1}};
    assign scoSum  = {1'b0, idEx.rd1} + {1'b0, idEx.rd2};
    assign scoBit  = scoSum[dataWidth];
    assign sltBit  = $signed(idEx.rd1) < $signed(idEx.rd2);
    assign sleBit  = $signed(idEx.rd1) <= $signed(idEx.rd2);
    assign seqBit  = (idEx.rd1 == idEx.rd2);

    always_comb begin
        case (resSel)
            selAlu:  result = aluOut;
            selSlbi: result = slbiOut;
            selImm:  result = idEx.imm;
            selSlt:  result = {{(dataWidth-1){1'b0}}, sltBit};
            selSle:  result = {{(dataWidth-1){1'b0}}, sleBit};
            selSeq:  result = {{(dataWidth-1){1'b0}}, seqBit};
            selSco:  result = {{(dataWidth-1){1'b0}}, scoBit};
            selBtr:  result = btrOut;
            selLink: result = idEx.pc2;
            selStu:  result = memAddr;
            default: result = aluOut;
        endcase
    end

    always_comb begin
        exMemNext.aluResult = result;
        exMemNext.rd2       = idEx.rd2;
        exMemNext.imm       = idEx.imm;
        exMemNext.nextPc    = takeBranch ? target : idEx.pc2;
        exMemNext.redirect  = takeBranch;
        exMemNext.memToReg  = idEx.memToReg;
        exMemNext.memWrite  = idEx.memWrite;
        exMemNext.memRead   = idEx.memRead;
        exMemNext.dump      = idEx.dump;
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.err       = illegal;
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

    memAccessExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(exMem.memRead && exMem.memWrite)
    ) else $error("execute: memRead and memWrite both set");

    // compare results must agree with the ALU flags of the same subtract or add
    aluFlagsAgree: assert property (
        @(posedge clk) disable iff (reset)
        !idEx.aluSrc |->
            (idEx.opClass != sltOp || sltBit == (aluNeg ^ aluOfl)) &&
            (idEx.opClass != seqOp || seqBit == aluZero) &&
            (idEx.opClass != scoOp || scoBit == aluCarry)
    ) else $error("execute: compare result disagrees with ALU flags");

endmodule

// ==== include/executeModel.svh ====
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// expected EX/MEM bundle for one ID/EX bundle
function automatic pipePkg::exMemT executeModel(input pipePkg::idExT idEx);
    pipePkg::exMemT   exp;
    isaPkg::opClassT  cls;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [3:0]       s;
    logic [16:0]      sum;
    logic [15:0]      rev;
    logic             cond;
    logic             taken;
    cls = idEx.opClass;
    a   = idEx.rd1;
    b   = (cls == isaPkg::branchOp) ? 16'h0 : (idEx.aluSrc ? idEx.imm : idEx.rd2);
    s   = b[3:0];
    sum = {1'b0, a} + {1'b0, idEx.rd2};
    // bit 0 of the result takes bit 15 of rd1
    for (int i = 0; i < 16; i++) begin
        rev[i] = a[15 - i];
    end
    case (cls)
        isaPkg::rArith: exp.aluResult = (idEx.aluFunc == 2'd0) ? a + b :
                                        (idEx.aluFunc == 2'd1) ? a - b :
                                        (idEx.aluFunc == 2'd2) ? a ^ b : a & ~b;
        isaPkg::rShift: exp.aluResult = (idEx.aluFunc == 2'd0) ? (a << s) | (a >> (5'd16 - s)) :
                                        (idEx.aluFunc == 2'd1) ? a << s :
                                        (idEx.aluFunc == 2'd2) ? (a >> s) | (a << (5'd16 - s)) :
                                        a >> s;
        isaPkg::subI:   exp.aluResult = a - b;
        isaPkg::xorI:   exp.aluResult = a ^ b;
        isaPkg::andnI:  exp.aluResult = a & ~b;
        isaPkg::rolI:   exp.aluResult = (a << s) | (a >> (5'd16 - s));
        isaPkg::sllI:   exp.aluResult = a << s;
        isaPkg::rorI:   exp.aluResult = (a >> s) | (a << (5'd16 - s));
        isaPkg::srlI:   exp.aluResult = a >> s;
        isaPkg::seqOp:  exp.aluResult = (a == idEx.rd2) ? 16'd1 : 16'd0;
        isaPkg::sltOp:  exp.aluResult = ($signed(a) < $signed(idEx.rd2)) ? 16'd1 : 16'd0;
        isaPkg::sleOp:  exp.aluResult = ($signed(a) <= $signed(idEx.rd2)) ? 16'd1 : 16'd0;
        isaPkg::scoOp:  exp.aluResult = {15'd0, sum[16]};
        isaPkg::btrOp:  exp.aluResult = rev;
        isaPkg::lbiOp:  exp.aluResult = idEx.imm;
        isaPkg::slbiOp: exp.aluResult = (a << 8) | idEx.imm;
        isaPkg::loadOp, isaPkg::storeOp, isaPkg::stuOp: exp.aluResult = a + idEx.imm;
        isaPkg::jalOp, isaPkg::jalrOp: exp.aluResult = idEx.pc2;
        default:        exp.aluResult = a + b;
    endcase
    case (idEx.branchCond)
        isaPkg::eqz: cond = (a == 16'h0);
        isaPkg::nez: cond = (a != 16'h0);
        isaPkg::ltz: cond = a[15];
        default:     cond = !a[15];
    endcase
    taken = (cls inside {isaPkg::jOp, isaPkg::jrOp, isaPkg::jalOp, isaPkg::jalrOp}) ||
            (cls == isaPkg::branchOp && cond);
    exp.nextPc   = !taken ? idEx.pc2 :
                   (cls inside {isaPkg::jrOp, isaPkg::jalrOp}) ? a + idEx.imm :
                   idEx.pc2 + idEx.imm;
    exp.redirect = taken;
    exp.rd2      = idEx.rd2;
    exp.imm      = idEx.imm;
    exp.memToReg = idEx.memToReg;
    exp.memWrite = idEx.memWrite;
    exp.memRead  = idEx.memRead;
    exp.dump     = idEx.dump;
    exp.regWrite = idEx.regWrite;
    exp.err      = (cls > isaPkg::jalrOp);
    return exp;
endfunction

`endif

// ==== testbench/executeTb.sv ====
`timescale 1ns/1ps

module executeTb;
    import isaPkg::*;
    import pipePkg::*;

    `include "executeModel.svh"

    localparam int resetLen       = 16;
    localparam int directedCycles = 32 * 25;
    localparam int randomCycles   = 3000;
    localparam int cycleLimit     = 5000;

    logic  clk;
    logic  reset;
    idExT  idEx;
    exMemT exMem;

    idExT  prevIdEx;
    logic  prevReset;
    logic  checkArmed = 1'b0;
    exMemT expected;
    int    errorCount = 0;
    int    checkCount = 0;
    logic  timedOut = 1'b0;

    logic [15:0] corners [5] = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000, 16'h0001};

    execute uut (
        .clk   (clk),
        .reset (reset),
        .idEx  (idEx),
        .exMem (exMem)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // bundle registered by the DUT on the last edge
    always_ff @(posedge clk) begin
        prevIdEx   <= idEx;
        prevReset  <= reset;
        checkArmed <= 1'b1;
        if (checkArmed) begin
            checkCount <= checkCount + 1;
        end
    end

    always_comb begin
        expected = prevReset ? '0 : executeModel(prevIdEx);
    end

    task automatic reportMismatch(input string field, input logic [15:0] expVal,
                                  input logic [15:0] actVal);
        errorCount++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, field, expVal, actVal);
    endtask

    function automatic idExT makeBundle(input logic [4:0] cls, input logic [15:0] a,
                                        input logic [15:0] b);
        idExT       bundle;
        logic [1:0] memCtl;
        memCtl            = 2'($urandom() % 3);
        bundle.pc2        = 16'($urandom());
        bundle.rd1        = a;
        bundle.rd2        = b;
        bundle.imm        = ($urandom() % 2 == 0) ? b : 16'($urandom());
        bundle.opClass    = opClassT'(cls);
        bundle.aluFunc    = 2'($urandom());
        bundle.branchCond = branchCondT'(2'($urandom()));
        bundle.aluSrc     = 1'($urandom());
        bundle.regWrite   = 1'($urandom());
        bundle.memToReg   = 1'($urandom());
        // read and write never together
        bundle.memRead    = (memCtl == 2'd1);
        bundle.memWrite   = (memCtl == 2'd2);
        bundle.dump       = 1'($urandom());
        return bundle;
    endfunction

    aluResultCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.aluResult == expected.aluResult
    ) else reportMismatch("aluResult", $sampled(expected.aluResult), $sampled(exMem.aluResult));

    rd2Check: assert property (@(posedge clk) checkArmed |-> exMem.rd2 == expected.rd2)
        else reportMismatch("rd2", $sampled(expected.rd2), $sampled(exMem.rd2));

    immCheck: assert property (@(posedge clk) checkArmed |-> exMem.imm == expected.imm)
        else reportMismatch("imm", $sampled(expected.imm), $sampled(exMem.imm));

    nextPcCheck: assert property (@(posedge clk) checkArmed |-> exMem.nextPc == expected.nextPc)
        else reportMismatch("nextPc", $sampled(expected.nextPc), $sampled(exMem.nextPc));

    redirectCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.redirect == expected.redirect
    ) else reportMismatch("redirect", 16'($sampled(expected.redirect)),
                          16'($sampled(exMem.redirect)));

    memToRegCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.memToReg == expected.memToReg
    ) else reportMismatch("memToReg", 16'($sampled(expected.memToReg)),
                          16'($sampled(exMem.memToReg)));

    memWriteCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.memWrite == expected.memWrite
    ) else reportMismatch("memWrite", 16'($sampled(expected.memWrite)),
                          16'($sampled(exMem.memWrite)));

    memReadCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.memRead == expected.memRead
    ) else reportMismatch("memRead", 16'($sampled(expected.memRead)),
                          16'($sampled(exMem.memRead)));

    dumpCheck: assert property (@(posedge clk) checkArmed |-> exMem.dump == expected.dump)
        else reportMismatch("dump", 16'($sampled(expected.dump)), 16'($sampled(exMem.dump)));

    regWriteCheck: assert property (
        @(posedge clk) checkArmed |-> exMem.regWrite == expected.regWrite
    ) else reportMismatch("regWrite", 16'($sampled(expected.regWrite)),
                          16'($sampled(exMem.regWrite)));

    errCheck: assert property (@(posedge clk) checkArmed |-> exMem.err == expected.err)
        else reportMismatch("err", 16'($sampled(expected.err)), 16'($sampled(exMem.err)));

    initial begin
        int          resetCount;
        int          runCount;
        int          guard;
        logic [15:0] a;
        logic [15:0] b;
        int          pick;
        void'($urandom(32'h6832));
        reset      = 1'b1;
        idEx       = '0;
        resetCount = 0;
        guard      = 0;

        // random bundles while reset is held must not leak out
        while (resetCount < resetLen && !timedOut) begin
            @(posedge clk);
            idEx <= makeBundle(5'($urandom()), 16'($urandom()), 16'($urandom()));
            resetCount++;
            guard++;
            if (guard > cycleLimit) begin
                timedOut = 1'b1;
            end
        end
        reset <= 1'b0;

        runCount = 0;
        guard    = 0;
        while (runCount < directedCycles + randomCycles && !timedOut) begin
            @(posedge clk);
            if (runCount < directedCycles) begin
                // every class against each pair of corner values
                idEx <= makeBundle(5'(runCount % 32), corners[(runCount / 32) % 5],
                                   corners[(runCount / 160) % 5]);
            end else begin
                a    = 16'($urandom());
                b    = 16'($urandom());
                pick = int'($urandom() % 4);
                if (pick == 0) begin
                    a = 16'h0000;
                end else if (pick == 1) begin
                    b = a;
                end
                idEx <= makeBundle(5'($urandom()), a, b);
            end
            runCount++;
            guard++;
            if (guard > cycleLimit) begin
                timedOut = 1'b1;
            end
        end

        // let the last bundle reach the checks
        guard = 0;
        while (guard < 3) begin
            @(negedge clk);
            guard++;
        end

        if (timedOut) begin
            $display("timeout: stimulus loop ran past %0d cycles", cycleLimit);
        end
        $display("checked %0d cycles, %0d errors", checkCount, errorCount);
        if (timedOut || errorCount != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

// ==== execStage.f ====
+incdir+include
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/aluCtrl.sv
verilog/alu.sv
verilog/branchCtrl.sv
verilog/execute.sv
testbench/executeTb.sv

// ==== runSim.sh ====
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f execStage.f --top-module executeTb -Mdir obj_dir

output=$(./obj_dir/VexecuteTb)
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
